// ==== mem_subsys.f ====
+incdir+source
source/mem_subsys_pkg.sv
source/axi_zone_xbar.sv
source/clint_timer.sv
source/sram_slave.sv
source/mem_subsys_top.sv
verif/tb_clock_gen.sv
verif/mem_subsys_sva.sv
verif/mem_subsys_checker.sv
verif/mem_subsys_tb.sv

// ==== Makefile ====
TOP := mem_subsys_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f mem_subsys.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== verif/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module mem_subsys_tb import mem_subsys_pkg::*; ();

  localparam int NUM_OPS   = 400;
  localparam int NUM_WORDS = 16;
  localparam int TIMEOUT   = 64;
  localparam int HS_AR     = 0;
  localparam int HS_R      = 1;
  localparam int HS_W      = 2;
  localparam int HS_B      = 3;

  logic                 clock;
  logic                 rst_n;
  logic                 arvalid;
  logic                 arready;
  logic [`ADDR_W-1:0]   araddr;
  logic                 rvalid;
  logic                 rready;
  logic [`DATA_W-1:0]   rdata;
  axi_resp_t            rresp;
  logic                 awvalid;
  logic                 awready;
  logic [`ADDR_W-1:0]   awaddr;
  logic                 wvalid;
  logic                 wready;
  logic [`DATA_W-1:0]   wdata;
  logic [`DATA_W/8-1:0] wstrb;
  logic                 bvalid;
  logic                 bready;
  axi_resp_t            bresp;
  logic                 diff_skip;
  int                   error_count;
  int                   check_count;
  int                   timeout_count;
  logic [31:0]          lfsr_state;

  tb_clock_gen clock_gen_i (
    .clock (clock)
  );

  mem_subsys_top mem_subsys_top_i (.*);

  mem_subsys_checker checker_i (.*);

  bind mem_subsys_top mem_subsys_sva mem_subsys_sva_i (.*);

  // ************************************************************************
  // Random source, Galois LFSR x^32+x^22+x^2+x+1
  // ************************************************************************
  function automatic logic next_rand_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[62:0], next_rand_bit()};
    return v;
  endfunction

  // Ready high three cycles out of four
  function automatic logic ready_draw();
    logic a;
    logic b;
    a = next_rand_bit();
    b = next_rand_bit();
    return a | b;
  endfunction

  // Spread the used words over both ends of the array
  function automatic logic [`ADDR_W-1:0] sram_word_addr(input logic [3:0] off);
    return `SRAM_BASE + {20'h0, off[3:2], 5'b0, off[1:0], 3'b0};
  endfunction

  function automatic logic [`ADDR_W-1:0] pick_addr();
    logic [63:0] zone;
    logic [63:0] sel;
    zone = rand_bits(2);
    case (zone[1:0])
      2'd0, 2'd1: begin
        sel = rand_bits(4);
        return sram_word_addr(sel[3:0]);
      end
      2'd2: return next_rand_bit() ? `RTC_ADDR_HIGH : `RTC_ADDR;
      default: begin
        sel = rand_bits(33);
        case (sel[32:31])
          2'd0:    return `SRAM_BASE - 32'd8;
          2'd1:    return `SRAM_BASE + `SRAM_SIZE;
          2'd2:    return `RTC_ADDR - 32'd8;
          default: return {1'b1, sel[30:0]};
        endcase
      end
    endcase
  endfunction

  // ************************************************************************
  // Bus tasks
  // ************************************************************************
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // Returns just after the rising edge that completes the selected transfer
  task automatic wait_handshake(input int which, input string what, output logic ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < TIMEOUT) begin
      if (which == HS_R)
        rready = ready_draw();
      else if (which == HS_B)
        bready = ready_draw();
      @(negedge clock);
      case (which)
        HS_AR:   ok = arready;
        HS_R:    ok = rvalid && rready;
        HS_W:    ok = awready && wready;
        default: ok = bvalid && bready;
      endcase
      if (!ok) begin
        next_cycle();
        cycles++;
      end
    end
    if (ok) begin
      next_cycle();
    end else begin
      timeout_count++;
      $display("Timeout: %s handshake did not complete within %0d cycles", what, TIMEOUT);
    end
  endtask

  task automatic do_read(input logic [`ADDR_W-1:0] addr);
    logic        ok;
    logic [63:0] r;
    arvalid = 1'b1;
    araddr  = addr;
    wait_handshake(HS_AR, "read address", ok);
    if (ok) begin
      // Address may wander once accepted
      r = rand_bits(32);
      arvalid = 1'b0;
      araddr  = r[31:0];
      wait_handshake(HS_R, "read data", ok);
      rready = 1'b0;
    end
  endtask

  task automatic do_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data,
                          input logic [`DATA_W/8-1:0] strb);
    logic        ok;
    logic [63:0] r;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    wait_handshake(HS_W, "write address", ok);
    if (ok) begin
      r = rand_bits(32);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      awaddr  = r[31:0];
      wait_handshake(HS_B, "write response", ok);
      bready = 1'b0;
    end
  endtask

  initial begin
    logic [`ADDR_W-1:0] addr;
    logic [63:0]        data;
    logic [63:0]        strb;
    lfsr_state    = 32'h6986_3252;
    timeout_count = 0;
    rst_n   = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    repeat (8) @(posedge clock);
    #1;
    rst_n = 1'b1;

    // Words used later start out fully written
    for (int w = 0; w < NUM_WORDS && timeout_count == 0; w++) begin
      data = rand_bits(64);
      do_write(sram_word_addr(w[3:0]), data, 8'hff);
    end

    for (int n = 0; n < NUM_OPS && timeout_count == 0; n++) begin
      addr = pick_addr();
      if (next_rand_bit()) begin
        do_read(addr);
      end else begin
        data = rand_bits(64);
        strb = rand_bits(8);
        do_write(addr, data, strb[7:0]);
      end
    end

    repeat (4) next_cycle();
    $display("Checks: %0d  check errors: %0d  timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0 && check_count > 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/mem_subsys_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module mem_subsys_checker import mem_subsys_pkg::*; (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 arvalid,
  input  logic                 arready,
  input  logic [`ADDR_W-1:0]   araddr,
  input  logic                 rvalid,
  input  logic                 rready,
  input  logic [`DATA_W-1:0]   rdata,
  input  axi_resp_t            rresp,
  input  logic                 awvalid,
  input  logic                 awready,
  input  logic [`ADDR_W-1:0]   awaddr,
  input  logic                 wvalid,
  input  logic                 wready,
  input  logic [`DATA_W-1:0]   wdata,
  input  logic [`DATA_W/8-1:0] wstrb,
  input  logic                 bvalid,
  input  logic                 bready,
  input  axi_resp_t            bresp,
  input  logic                 diff_skip,
  output int                   error_count,
  output int                   check_count
);

  logic [`DATA_W-1:0] shadow_mem [`SRAM_DEPTH];
  logic [63:0]        shadow_mtime;
  logic [63:0]        next_mtime;
  logic               rd_pend;
  logic               wr_pend;
  logic               r_stalled;
  logic               b_stalled;
  logic [`DATA_W-1:0] exp_rdata;
  logic [`DATA_W-1:0] held_rdata;
  axi_resp_t          exp_rresp;
  axi_resp_t          held_rresp;
  axi_resp_t          exp_bresp;
  axi_resp_t          held_bresp;
  string              rd_name;
  string              wr_name;

  function automatic zone_t zone_of(input logic [`ADDR_W-1:0] addr);
    if (addr >= `SRAM_BASE && addr - `SRAM_BASE < `SRAM_SIZE)
      return ZONE_SRAM;
    if (addr == `RTC_ADDR || addr == `RTC_ADDR_HIGH)
      return ZONE_TIMER;
    return ZONE_NONE;
  endfunction

  function automatic int sram_index(input logic [`ADDR_W-1:0] addr);
    logic [31:0] off;
    off = addr - `SRAM_BASE;
    return int'(off >> 3);
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error %s at %0t: expected %h, actual %h", name, $time, expected, actual);
    end
  endtask

  task automatic protocol_error(input string msg);
    error_count++;
    $display("Protocol error at %0t: %s", $time, msg);
  endtask

  // Sampled at the falling edge, so every value is the one the next rising edge sees
  always @(negedge clock) begin : sample
    int   idx;
    logic skip_exp;
    if (!rst_n) begin
      rd_pend      = 1'b0;
      wr_pend      = 1'b0;
      r_stalled    = 1'b0;
      b_stalled    = 1'b0;
      shadow_mtime = '0;
    end else begin
      skip_exp = (arvalid && zone_of(araddr) == ZONE_TIMER) ||
                 (awvalid && zone_of(awaddr) == ZONE_TIMER);
      check_value("diff_skip", 64'(skip_exp), 64'(diff_skip));

      if (rd_pend && arready)
        protocol_error("arready was high while a read was outstanding");
      if (wr_pend && (awready || wready))
        protocol_error("awready or wready was high while a write was outstanding");
      if (rvalid && !rd_pend)
        protocol_error("rvalid was high with no read outstanding");
      if (bvalid && !wr_pend)
        protocol_error("bvalid was high with no write outstanding");
      if (r_stalled && (!rvalid || rdata !== held_rdata || rresp !== held_rresp))
        protocol_error("read response changed before rready accepted it");
      if (b_stalled && (!bvalid || bresp !== held_bresp))
        protocol_error("write response changed before bready accepted it");

      // ********************************************************************
      // Responses
      // ********************************************************************
      if (rvalid && rready && rd_pend) begin
        check_value({rd_name, " rdata"}, exp_rdata, rdata);
        check_value({rd_name, " rresp"}, 64'(exp_rresp), 64'(rresp));
        rd_pend = 1'b0;
      end
      if (bvalid && bready && wr_pend) begin
        check_value({wr_name, " bresp"}, 64'(exp_bresp), 64'(bresp));
        wr_pend = 1'b0;
      end
      r_stalled  = rvalid && !rready;
      held_rdata = rdata;
      held_rresp = rresp;
      b_stalled  = bvalid && !bready;
      held_bresp = bresp;

      // ********************************************************************
      // Requests, reads see the state before a write of the same edge
      // ********************************************************************
      next_mtime = shadow_mtime + 64'd1;
      if (arvalid && arready) begin
        rd_pend   = 1'b1;
        exp_rresp = RESP_OKAY;
        case (zone_of(araddr))
          ZONE_SRAM: begin
            rd_name   = "sram read";
            exp_rdata = shadow_mem[sram_index(araddr)];
          end
          ZONE_TIMER: begin
            rd_name   = "timer read";
            exp_rdata = (araddr == `RTC_ADDR_HIGH) ? {32'h0, shadow_mtime[63:32]} : shadow_mtime;
          end
          default: begin
            rd_name   = "unmapped read";
            exp_rdata = '0;
            exp_rresp = RESP_DECERR;
          end
        endcase
      end

      if (awvalid && wvalid && awready && wready) begin
        wr_pend   = 1'b1;
        exp_bresp = RESP_OKAY;
        case (zone_of(awaddr))
          ZONE_SRAM: begin
            wr_name = "sram write";
            idx = sram_index(awaddr);
            for (int i = 0; i < `DATA_W/8; i++)
              if (wstrb[i])
                shadow_mem[idx][8*i +: 8] = wdata[8*i +: 8];
          end
          ZONE_TIMER: begin
            wr_name    = "timer write";
            next_mtime = shadow_mtime;
            for (int i = 0; i < 4; i++) begin
              if (wstrb[i]) begin
                if (awaddr == `RTC_ADDR_HIGH)
                  next_mtime[32 + 8*i +: 8] = wdata[8*i +: 8];
                else
                  next_mtime[8*i +: 8] = wdata[8*i +: 8];
              end
            end
          end
          default: begin
            wr_name   = "unmapped write";
            exp_bresp = RESP_DECERR;
          end
        endcase
      end
      shadow_mtime = next_mtime;
    end
  end

endmodule

`default_nettype wire

// ==== verif/mem_subsys_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module mem_subsys_sva import mem_subsys_pkg::*; (
  input logic               clock,
  input logic               rst_n,
  input logic               arvalid,
  input logic               arready,
  input logic               rvalid,
  input logic               rready,
  input logic [`DATA_W-1:0] rdata,
  input axi_resp_t          rresp,
  input logic               awvalid,
  input logic               awready,
  input logic               wvalid,
  input logic               wready,
  input logic               bvalid,
  input logic               bready,
  input axi_resp_t          bresp
);

  logic rd_outstanding;
  logic wr_outstanding;

  always_ff @(posedge clock) begin
    if (!rst_n)
      rd_outstanding <= 1'b0;
    else if (arvalid && arready)
      rd_outstanding <= 1'b1;
    else if (rvalid && rready)
      rd_outstanding <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (!rst_n)
      wr_outstanding <= 1'b0;
    else if (awvalid && wvalid && awready && wready)
      wr_outstanding <= 1'b1;
    else if (bvalid && bready)
      wr_outstanding <= 1'b0;
  end

  r_payload_stable: assert property (@(posedge clock) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("read response changed while rready was low");

  b_payload_stable: assert property (@(posedge clock) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("write response changed while bready was low");

  no_ar_while_pending: assert property (@(posedge clock) disable iff (!rst_n)
    rd_outstanding |-> !arready)
    else $error("arready high while a read is outstanding");

  no_aw_while_pending: assert property (@(posedge clock) disable iff (!rst_n)
    wr_outstanding |-> !awready && !wready)
    else $error("awready or wready high while a write is outstanding");

  // Responses quiet once reset has been applied
  valids_low_after_reset: assert property (@(posedge clock)
    !rst_n |=> !rvalid && !bvalid)
    else $error("rvalid or bvalid high right after reset");

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock
);

  // 4 ns period
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

endmodule

`default_nettype wire

// ==== source/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module mem_subsys_top import mem_subsys_pkg::*; (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    arvalid,
  output logic                    arready,
  input  logic [`ADDR_W-1:0]      araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output logic [`DATA_W-1:0]      rdata,
  output axi_resp_t               rresp,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`ADDR_W-1:0]      awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  logic [`DATA_W-1:0]      wdata,
  input  logic [`DATA_W/8-1:0]    wstrb,
  output logic                    bvalid,
  input  logic                    bready,
  output axi_resp_t               bresp,
  output logic                    diff_skip
);

  // SRAM channel
  logic                 arvalid_mem, arready_mem, rvalid_mem, rready_mem;
  logic                 awvalid_mem, awready_mem, wvalid_mem, wready_mem;
  logic                 bvalid_mem, bready_mem;
  logic [`ADDR_W-1:0]   araddr_mem, awaddr_mem;
  logic [`DATA_W-1:0]   rdata_mem, wdata_mem;
  logic [`DATA_W/8-1:0] wstrb_mem;
  axi_resp_t            rresp_mem, bresp_mem;

  // Timer channel
  logic                 arvalid_tmr, arready_tmr, rvalid_tmr, rready_tmr;
  logic                 awvalid_tmr, awready_tmr, wvalid_tmr, wready_tmr;
  logic                 bvalid_tmr, bready_tmr;
  logic [`ADDR_W-1:0]   araddr_tmr, awaddr_tmr;
  logic [`DATA_W-1:0]   rdata_tmr, wdata_tmr;
  logic [`DATA_W/8-1:0] wstrb_tmr;
  axi_resp_t            rresp_tmr, bresp_tmr;

  axi_zone_xbar axi_zone_xbar_i (
    .*
  );

  sram_slave sram_slave_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .arvalid (arvalid_mem),
    .arready (arready_mem),
    .araddr  (araddr_mem),
    .rvalid  (rvalid_mem),
    .rready  (rready_mem),
    .rdata   (rdata_mem),
    .rresp   (rresp_mem),
    .awvalid (awvalid_mem),
    .awready (awready_mem),
    .awaddr  (awaddr_mem),
    .wvalid  (wvalid_mem),
    .wready  (wready_mem),
    .wdata   (wdata_mem),
    .wstrb   (wstrb_mem),
    .bvalid  (bvalid_mem),
    .bready  (bready_mem),
    .bresp   (bresp_mem)
  );

  clint_timer clint_timer_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .arvalid (arvalid_tmr),
    .arready (arready_tmr),
    .araddr  (araddr_tmr),
    .rvalid  (rvalid_tmr),
    .rready  (rready_tmr),
    .rdata   (rdata_tmr),
    .rresp   (rresp_tmr),
    .awvalid (awvalid_tmr),
    .awready (awready_tmr),
    .awaddr  (awaddr_tmr),
    .wvalid  (wvalid_tmr),
    .wready  (wready_tmr),
    .wdata   (wdata_tmr),
    .wstrb   (wstrb_tmr),
    .bvalid  (bvalid_tmr),
    .bready  (bready_tmr),
    .bresp   (bresp_tmr)
  );

endmodule

`default_nettype wire

// ==== source/sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module sram_slave import mem_subsys_pkg::*; (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    arvalid,
  output logic                    arready,
  input  logic [`ADDR_W-1:0]      araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output logic [`DATA_W-1:0]      rdata,
  output axi_resp_t               rresp,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`ADDR_W-1:0]      awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  logic [`DATA_W-1:0]      wdata,
  input  logic [`DATA_W/8-1:0]    wstrb,
  output logic                    bvalid,
  input  logic                    bready,
  output axi_resp_t               bresp
);

  localparam int IDX_W = $clog2(`SRAM_DEPTH);

  logic [`DATA_W-1:0] mem [`SRAM_DEPTH];
  logic [IDX_W-1:0]   rd_idx;
  logic [IDX_W-1:0]   wr_idx;
  logic               ar_hs;
  logic               wr_hs;

  // Word index sits right above the byte offset
  assign rd_idx = araddr[IDX_W+2:3];
  assign wr_idx = awaddr[IDX_W+2:3];

  assign arready = !rvalid;
  assign awready = !bvalid;
  assign wready  = !bvalid;
  assign rresp   = RESP_OKAY;
  assign bresp   = RESP_OKAY;

  assign ar_hs = arvalid && arready;
  assign wr_hs = awvalid && wvalid && awready;

  // ************************************************************************
  // Storage
  // ************************************************************************
  always_ff @(posedge clock) begin
    if (wr_hs) begin
      for (int i = 0; i < `DATA_W/8; i++) begin
        if (wstrb[i])
          mem[wr_idx][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  // Held until accepted since no new read is taken meanwhile
  always_ff @(posedge clock) begin
    if (ar_hs)
      rdata <= mem[rd_idx];
  end

  // ************************************************************************
  // Response handshakes
  // ************************************************************************
  always_ff @(posedge clock) begin
    if (!rst_n)
      rvalid <= 1'b0;
    else if (ar_hs)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (!rst_n)
      bvalid <= 1'b0;
    else if (wr_hs)
      bvalid <= 1'b1;
    else if (bready)
      bvalid <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module clint_timer import mem_subsys_pkg::*; (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    arvalid,
  output logic                    arready,
  input  logic [`ADDR_W-1:0]      araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output logic [`DATA_W-1:0]      rdata,
  output axi_resp_t               rresp,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`ADDR_W-1:0]      awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  logic [`DATA_W-1:0]      wdata,
  input  logic [`DATA_W/8-1:0]    wstrb,
  output logic                    bvalid,
  input  logic                    bready,
  output axi_resp_t               bresp
);

  logic [63:0] mtime;
  logic [63:0] mtime_wr;
  logic        ar_hs;
  logic        wr_hs;

  assign arready = !rvalid;
  assign awready = !bvalid;
  assign wready  = !bvalid;
  assign rresp   = RESP_OKAY;
  assign bresp   = RESP_OKAY;

  assign ar_hs = arvalid && arready;
  assign wr_hs = awvalid && wvalid && awready;

  // Either half is carried in the low lanes; address bit 2 picks the half
  always_comb begin
    mtime_wr = mtime;
    for (int i = 0; i < 4; i++) begin
      if (wstrb[i]) begin
        if (awaddr[2])
          mtime_wr[32 + 8*i +: 8] = wdata[8*i +: 8];
        else
          mtime_wr[8*i +: 8] = wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n)
      mtime <= '0;
    else if (wr_hs)
      mtime <= mtime_wr;
    else
      mtime <= mtime + 64'd1;
  end

  always_ff @(posedge clock) begin
    if (!rst_n)
      rvalid <= 1'b0;
    else if (ar_hs)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  always_ff @(posedge clock) begin
    if (ar_hs)
      rdata <= araddr[2] ? {32'h0, mtime[63:32]} : mtime;
  end

  always_ff @(posedge clock) begin
    if (!rst_n)
      bvalid <= 1'b0;
    else if (wr_hs)
      bvalid <= 1'b1;
    else if (bready)
      bvalid <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== source/axi_zone_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_defines.svh"

module axi_zone_xbar import mem_subsys_pkg::*; (
  input  logic                    clock,
  input  logic                    rst_n,
  // Master side
  input  logic                    arvalid,
  output logic                    arready,
  input  logic [`ADDR_W-1:0]      araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output logic [`DATA_W-1:0]      rdata,
  output axi_resp_t               rresp,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`ADDR_W-1:0]      awaddr,
  input  logic                    wvalid,
  output logic                    wready,
  input  logic [`DATA_W-1:0]      wdata,
  input  logic [`DATA_W/8-1:0]    wstrb,
  output logic                    bvalid,
  input  logic                    bready,
  output axi_resp_t               bresp,
  output logic                    diff_skip,
  // SRAM side
  output logic                    arvalid_mem, rready_mem, awvalid_mem, wvalid_mem, bready_mem,
  output logic [`ADDR_W-1:0]      araddr_mem, awaddr_mem,
  output logic [`DATA_W-1:0]      wdata_mem,
  output logic [`DATA_W/8-1:0]    wstrb_mem,
  input  logic                    arready_mem, rvalid_mem, awready_mem, wready_mem, bvalid_mem,
  input  logic [`DATA_W-1:0]      rdata_mem,
  input  axi_resp_t               rresp_mem, bresp_mem,
  // Timer side
  output logic                    arvalid_tmr, rready_tmr, awvalid_tmr, wvalid_tmr, bready_tmr,
  output logic [`ADDR_W-1:0]      araddr_tmr, awaddr_tmr,
  output logic [`DATA_W-1:0]      wdata_tmr,
  output logic [`DATA_W/8-1:0]    wstrb_tmr,
  input  logic                    arready_tmr, rvalid_tmr, awready_tmr, wready_tmr, bvalid_tmr,
  input  logic [`DATA_W-1:0]      rdata_tmr,
  input  axi_resp_t               rresp_tmr, bresp_tmr
);

  zone_t ar_zone;
  zone_t aw_zone;
  zone_t rd_zone;
  zone_t wr_zone;
  logic  rd_pend;
  logic  wr_pend;
  logic  ar_hs;
  logic  r_hs;
  logic  wr_hs;
  logic  b_hs;

  function automatic zone_t decode_zone(input logic [`ADDR_W-1:0] addr);
    if (addr >= `SRAM_BASE && addr < `SRAM_BASE + `SRAM_SIZE)
      return ZONE_SRAM;
    else if (addr == `RTC_ADDR || addr == `RTC_ADDR_HIGH)
      return ZONE_TIMER;
    else
      return ZONE_NONE;
  endfunction

  assign ar_zone = decode_zone(araddr);
  assign aw_zone = decode_zone(awaddr);

  // Timer accesses are not mirrored by the reference model
  assign diff_skip = (arvalid && ar_zone == ZONE_TIMER) ||
                     (awvalid && aw_zone == ZONE_TIMER);

  assign ar_hs = arvalid && arready;
  assign r_hs  = rvalid && rready;
  assign wr_hs = awvalid && wvalid && awready;
  assign b_hs  = bvalid && bready;

  // ************************************************************************
  // Zone latched at the address handshake, held until the response
  // ************************************************************************
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      rd_zone <= ZONE_NONE;
    end else if (ar_hs) begin
      rd_pend <= 1'b1;
      rd_zone <= ar_zone;
    end else if (r_hs) begin
      rd_pend <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wr_pend <= 1'b0;
      wr_zone <= ZONE_NONE;
    end else if (wr_hs) begin
      wr_pend <= 1'b1;
      wr_zone <= aw_zone;
    end else if (b_hs) begin
      wr_pend <= 1'b0;
    end
  end

  // ************************************************************************
  // Read path
  // ************************************************************************
  assign araddr_mem  = araddr;
  assign araddr_tmr  = araddr;
  assign arvalid_mem = arvalid && !rd_pend && ar_zone == ZONE_SRAM;
  assign arvalid_tmr = arvalid && !rd_pend && ar_zone == ZONE_TIMER;
  assign rready_mem  = rready && rd_pend && rd_zone == ZONE_SRAM;
  assign rready_tmr  = rready && rd_pend && rd_zone == ZONE_TIMER;

  always_comb begin
    arready = 1'b0;
    if (!rd_pend) begin
      case (ar_zone)
        ZONE_SRAM:  arready = arready_mem;
        ZONE_TIMER: arready = arready_tmr;
        default:    arready = 1'b1;
      endcase
    end
  end

  always_comb begin
    rvalid = 1'b0;
    rdata  = '0;
    rresp  = RESP_DECERR;
    case (rd_zone)
      ZONE_SRAM: begin
        rvalid = rd_pend && rvalid_mem;
        rdata  = rdata_mem;
        rresp  = rresp_mem;
      end
      ZONE_TIMER: begin
        rvalid = rd_pend && rvalid_tmr;
        rdata  = rdata_tmr;
        rresp  = rresp_tmr;
      end
      // Unmapped, answered here a cycle after the handshake
      default: rvalid = rd_pend;
    endcase
  end

  // ************************************************************************
  // Write path
  // ************************************************************************
  assign awaddr_mem  = awaddr;
  assign awaddr_tmr  = awaddr;
  assign wdata_mem   = wdata;
  assign wdata_tmr   = wdata;
  assign wstrb_mem   = wstrb;
  assign wstrb_tmr   = wstrb;
  assign awvalid_mem = awvalid && !wr_pend && aw_zone == ZONE_SRAM;
  assign awvalid_tmr = awvalid && !wr_pend && aw_zone == ZONE_TIMER;
  assign wvalid_mem  = wvalid && !wr_pend && aw_zone == ZONE_SRAM;
  assign wvalid_tmr  = wvalid && !wr_pend && aw_zone == ZONE_TIMER;
  assign bready_mem  = bready && wr_pend && wr_zone == ZONE_SRAM;
  assign bready_tmr  = bready && wr_pend && wr_zone == ZONE_TIMER;

  always_comb begin
    awready = 1'b0;
    wready  = 1'b0;
    if (!wr_pend) begin
      case (aw_zone)
        ZONE_SRAM: begin
          awready = awready_mem;
          wready  = wready_mem;
        end
        ZONE_TIMER: begin
          awready = awready_tmr;
          wready  = wready_tmr;
        end
        default: begin
          awready = 1'b1;
          wready  = 1'b1;
        end
      endcase
    end
  end

  always_comb begin
    bvalid = 1'b0;
    bresp  = RESP_DECERR;
    case (wr_zone)
      ZONE_SRAM: begin
        bvalid = wr_pend && bvalid_mem;
        bresp  = bresp_mem;
      end
      ZONE_TIMER: begin
        bvalid = wr_pend && bvalid_tmr;
        bresp  = bresp_tmr;
      end
      default: bvalid = wr_pend;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/mem_subsys_pkg.sv ====
`default_nettype none

package mem_subsys_pkg;

  // Target of an access, decided from its address
  typedef enum logic [1:0] {
    ZONE_SRAM  = 2'd0,
    ZONE_TIMER = 2'd1,
    ZONE_NONE  = 2'd2
  } zone_t;

  // AXI response codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_DECERR = 2'd3
  } axi_resp_t;

endpackage

`default_nettype wire

// ==== source/mem_subsys_defines.svh ====
`ifndef MEM_SUBSYS_DEFINES_SVH
`define MEM_SUBSYS_DEFINES_SVH

// Port widths
`define ADDR_W 32
`define DATA_W 64

// On-chip SRAM window, 64-bit words
`define SRAM_BASE  32'h0f00_0000
`define SRAM_SIZE  32'h0000_1000
`define SRAM_DEPTH (`SRAM_SIZE / 8)

// Machine timer words
`define RTC_ADDR      32'h0200_bff8
`define RTC_ADDR_HIGH (`RTC_ADDR + 32'd4)

`endif
